//--- compile.f
verilog/c4_pkg.sv
verilog/key_decoder.sv
verilog/game_control.sv
verilog/board_memory.sv
verilog/win_checker.sv
verilog/cell_plotter.sv
verilog/connect_four_top.sv
tb/connect_four_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert --top-module connect_four_tb -f compile.f -o connect_four_sim

sim_output=$(./obj_dir/connect_four_sim)
echo "$sim_output"

grep -q "^=== PASS ===$" <<< "$sim_output"

//--- tb/connect_four_tb.sv
`timescale 1ns/1ps
`default_nettype none

module connect_four_tb import c4_pkg::*; ();

	localparam int NUM_DROPS       = 36; // Drop attempts over all games
	localparam int WATCHDOG_CYCLES = NUM_DROPS * 60 + 200;

	localparam int VERT_MOVES  [7]  = '{1, 2, 1, 2, 1, 2, 1};
	localparam int HORIZ_MOVES [7]  = '{0, 4, 1, 5, 2, 6, 3};
	localparam int DIAG_MOVES  [11] = '{0, 1, 1, 2, 2, 3, 2, 3, 3, 6, 3};

	logic    clk;
	logic    reset_n;
	scan_t   scan;
	logic    plot;
	pixel_t  pixel;
	player_t turn;
	player_t winner;
	logic    game_over;

	int value_errors;
	int other_errors;

	// Reference model of the game
	player_t model_board [NUM_ROWS][NUM_COLS];
	int      model_height [NUM_COLS];
	player_t model_turn;
	player_t model_winner;

	logic [31:0] lfsr_state = 32'd86940;

	connect_four_top dut_i (
		.clk       (clk),
		.reset_n   (reset_n),
		.scan      (scan),
		.plot      (plot),
		.pixel     (pixel),
		.turn      (turn),
		.winner    (winner),
		.game_over (game_over)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Nothing may be drawn once the game has ended
	quiet_after_game_over: assert property (@(posedge clk) disable iff (!reset_n)
		game_over |-> !plot) else begin
		value_errors++;
		$display("Fail plot got %h expected %h", plot, 1'b0);
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic next_bit();
		logic out;

		out        = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out)
			lfsr_state = lfsr_state ^ 32'h80200003;
		return out;
	endfunction

	function automatic logic [7:0] take_bits(input int n);
		logic [7:0] v;

		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[6:0], next_bit()};
		return v;
	endfunction

	function automatic logic [7:0] col_key(input int col);
		case (col)
			0:       return KEY_Z;
			1:       return KEY_X;
			2:       return KEY_C;
			3:       return KEY_V;
			4:       return KEY_B;
			5:       return KEY_N;
			default: return KEY_M;
		endcase
	endfunction

	// Count the run through (r, c) in each of the four line directions
	function automatic logic wins_at(input int r, input int c, input player_t p);
		int dr [4] = '{0, 1, 1, 1};
		int dc [4] = '{1, 0, 1, -1};
		int n;
		int rr;
		int cc;

		for (int d = 0; d < 4; d++) begin
			n = 1;
			for (int s = -1; s <= 1; s += 2) begin
				rr = r + s * dr[d];
				cc = c + s * dc[d];
				while (rr >= 0 && rr < NUM_ROWS && cc >= 0 && cc < NUM_COLS &&
					model_board[rr][cc] == p) begin
					n++;
					rr += s * dr[d];
					cc += s * dc[d];
				end
			end
			if (n >= WIN_LEN)
				return 1'b1;
		end
		return 1'b0;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got == exp) else begin
			value_errors++;
			$display("Fail %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic send_scan(input logic make, input logic [7:0] code);
		@(negedge clk);
		scan = '{valid: 1'b1, make: make, code: code};
		@(negedge clk);
		scan = '0;
	endtask

	// Releases of game keys and presses of keys the game does not use
	task automatic send_junk();
		logic [7:0] code;
		logic [7:0] sel;
		logic       make;

		code = take_bits(8);
		make = next_bit();
		if (code inside {KEY_Z, KEY_X, KEY_C, KEY_V, KEY_B, KEY_N, KEY_M, KEY_SPACE})
			make = 1'b0;
		if (!make) begin
			sel  = take_bits(3);
			code = (sel == 8'd7) ? KEY_SPACE : col_key(int'(sel));
		end
		send_scan(make, code);
	endtask

	task automatic apply_reset();
		@(negedge clk);
		reset_n = 1'b0;
		scan    = '0;
		repeat (2) @(negedge clk);
		reset_n = 1'b1;
		foreach (model_board[r, c])
			model_board[r][c] = PLAYER_NONE;
		foreach (model_height[c])
			model_height[c] = 0;
		model_turn   = PLAYER_RED;
		model_winner = PLAYER_NONE;
		check_value("plot", 32'(plot), 32'(0));
		check_value("game_over", 32'(game_over), 32'(0));
		check_value("winner", 32'(winner), 32'(PLAYER_NONE));
		check_value("turn", 32'(turn), 32'(PLAYER_RED));
	endtask

	//////////////////////////////////////////////////////////////////////
	// One drop, accepted or refused as the model decides
	//////////////////////////////////////////////////////////////////////

	task automatic drop_piece(input int col);
		int         row;
		int         delay;
		logic       accept;
		player_t    p;
		logic [2:0] color;

		accept = (model_winner == PLAYER_NONE) && (model_height[col] < NUM_ROWS);
		row    = NUM_ROWS - 1 - model_height[col];
		p      = model_turn;
		color  = (p == PLAYER_RED) ? COLOR_RED : COLOR_BLUE;
		send_scan(1'b1, col_key(col));
		send_junk();
		send_junk();
		check_value("turn", 32'(turn), 32'(model_turn));
		send_scan(1'b1, KEY_SPACE);
		if (!accept) begin
			repeat (8) begin
				@(negedge clk);
				check_value("plot", 32'(plot), 32'(0));
			end
			check_value("turn", 32'(turn), 32'(model_turn));
			check_value("winner", 32'(winner), 32'(model_winner));
			return;
		end
		delay = 0;
		while (!plot && delay < 8) begin
			@(negedge clk);
			delay++;
		end
		if (!plot) begin
			other_errors++;
			$display("No pixel was plotted after an accepted drop into column %0d", col);
			return;
		end
		check_value("plot_delay", 32'(delay), 32'(4));
		check_value("game_over", 32'(game_over), 32'(0));
		for (int yo = 0; yo < BLOCK_SIZE; yo++) begin
			for (int xo = 0; xo < BLOCK_SIZE; xo++) begin
				if (yo != 0 || xo != 0)
					@(negedge clk);
				check_value("plot", 32'(plot), 32'(1));
				check_value("pixel.x", 32'(pixel.x), 32'(CELL_X0 + CELL_X_PITCH * col + xo));
				check_value("pixel.y", 32'(pixel.y), 32'(CELL_Y0 + CELL_Y_PITCH * row + yo));
				check_value("pixel.color", 32'(pixel.color), 32'(color));
			end
		end
		@(negedge clk);
		check_value("plot", 32'(plot), 32'(0)); // Exactly 36 pixels
		model_board[row][col] = p;
		model_height[col]++;
		if (wins_at(row, col, p))
			model_winner = p;
		else
			model_turn = (p == PLAYER_RED) ? PLAYER_BLUE : PLAYER_RED;
		check_value("game_over", 32'(game_over), 32'(model_winner != PLAYER_NONE));
		check_value("winner", 32'(winner), 32'(model_winner));
		check_value("turn", 32'(turn), 32'(model_turn));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		reset_n      = 1'b0;
		scan         = '0;
		value_errors = 0;
		other_errors = 0;

		// Full column then a vertical win
		apply_reset();
		for (int i = 0; i < NUM_ROWS; i++)
			drop_piece(0);
		drop_piece(0); // Column already full
		for (int i = 0; i < 7; i++)
			drop_piece(VERT_MOVES[i]);
		drop_piece(4);

		apply_reset();
		for (int i = 0; i < 7; i++)
			drop_piece(HORIZ_MOVES[i]);
		drop_piece(5);

		apply_reset();
		for (int i = 0; i < 11; i++)
			drop_piece(DIAG_MOVES[i]);
		drop_piece(0);

		$display("Checks done with %0d value errors and %0d other errors",
			value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		other_errors++;
		$display("Watchdog expired before the test sequence finished");
		$display("Checks done with %0d value errors and %0d other errors",
			value_errors, other_errors);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/board_memory.sv
`timescale 1ns/1ps
`default_nettype none

module board_memory import c4_pkg::*; (
	input  logic    clk,
	input  logic    reset_n,
	input  col_t    column,
	input  logic    drop_en,
	input  player_t drop_player,
	output logic    col_full,
	output row_t    land_row,
	output board_t  board
);

	// Pieces already stacked in each column
	logic [2:0] heights [NUM_COLS];

	//////////////////////////////////////////////////////////////////////
	// Landing position of the selected column
	//////////////////////////////////////////////////////////////////////

	assign col_full = (heights[column] == 3'(NUM_ROWS));
	assign land_row = row_t'(NUM_ROWS - 1 - int'(heights[column])); // Counted from the top

	//////////////////////////////////////////////////////////////////////
	// Cell and height update
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			board <= '0; // Empty board
			for (int c = 0; c < NUM_COLS; c++)
				heights[c] <= 3'd0;
		end else if (drop_en) begin
			// Fullness checked upstream
			board[land_row][column] <= drop_player;
			heights[column]         <= heights[column] + 3'd1;
		end
	end

endmodule

`default_nettype wire

//--- verilog/c4_pkg.sv
`default_nettype none

package c4_pkg;

	//////////////////////////////////////////////////////////////////////
	// Board geometry and display mapping
	//////////////////////////////////////////////////////////////////////

	localparam int NUM_COLS = 7;
	localparam int NUM_ROWS = 7;
	localparam int WIN_LEN  = 4;

	localparam int CELL_X0      = 8;  // Pixel origin of column 0
	localparam int CELL_Y0      = 5;  // Pixel origin of row 0
	localparam int CELL_X_PITCH = 22;
	localparam int CELL_Y_PITCH = 16;
	localparam int BLOCK_SIZE   = 6;

	localparam logic [2:0] COLOR_RED  = 3'b100;
	localparam logic [2:0] COLOR_BLUE = 3'b001;

	// Keyboard scan codes, set 2
	localparam logic [7:0] KEY_Z     = 8'h1A;
	localparam logic [7:0] KEY_X     = 8'h22;
	localparam logic [7:0] KEY_C     = 8'h21;
	localparam logic [7:0] KEY_V     = 8'h2A;
	localparam logic [7:0] KEY_B     = 8'h32;
	localparam logic [7:0] KEY_N     = 8'h31;
	localparam logic [7:0] KEY_M     = 8'h3A;
	localparam logic [7:0] KEY_SPACE = 8'h29;

	//////////////////////////////////////////////////////////////////////
	// Shared types
	//////////////////////////////////////////////////////////////////////

	typedef logic [2:0] col_t;
	typedef logic [2:0] row_t;

	typedef enum logic [1:0] {
		PLAYER_NONE = 2'd0,
		PLAYER_RED  = 2'd1,
		PLAYER_BLUE = 2'd2
	} player_t;

	// Row 0 is the top of the board
	typedef player_t [NUM_ROWS-1:0][NUM_COLS-1:0] board_t;

	typedef struct packed {
		logic       valid;
		logic       make;  // 1 for key press, 0 for release
		logic [7:0] code;
	} scan_t;

	typedef struct packed {
		col_t    column;
		row_t    row;
		player_t player;
	} move_t;

	typedef struct packed {
		logic [7:0] x;
		logic [6:0] y;
		logic [2:0] color;
	} pixel_t;

endpackage

`default_nettype wire

//--- verilog/cell_plotter.sv
`timescale 1ns/1ps
`default_nettype none

module cell_plotter import c4_pkg::*; (
	input  logic   clk,
	input  logic   reset_n,
	input  logic   plot_start,
	input  move_t  move,
	output logic   plot,
	output pixel_t pixel,
	output logic   plot_done
);

	move_t      mv;     // Move being drawn
	logic [2:0] x_off;
	logic [2:0] y_off;
	logic       x_last;
	logic       y_last;

	assign x_last = (x_off == 3'(BLOCK_SIZE - 1));
	assign y_last = (y_off == 3'(BLOCK_SIZE - 1));

	always_ff @(posedge clk) begin
		if (plot_start)
			mv <= move;
	end

	//////////////////////////////////////////////////////////////////////
	// Block walk, x offset fastest
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			plot  <= 1'b0;
			x_off <= 3'd0;
			y_off <= 3'd0;
		end else if (plot_start) begin
			plot  <= 1'b1;
			x_off <= 3'd0;
			y_off <= 3'd0;
		end else if (plot) begin
			if (x_last) begin
				x_off <= 3'd0;
				y_off <= y_off + 3'd1;
				if (y_last)
					plot <= 1'b0; // Block complete
			end else begin
				x_off <= x_off + 3'd1;
			end
		end
	end

	assign plot_done = plot && x_last && y_last;

	// Cell origin from the geometry plus the running offset
	assign pixel.x     = 8'(CELL_X0 + CELL_X_PITCH * int'(mv.column) + int'(x_off));
	assign pixel.y     = 7'(CELL_Y0 + CELL_Y_PITCH * int'(mv.row) + int'(y_off));
	assign pixel.color = (mv.player == PLAYER_RED) ? COLOR_RED : COLOR_BLUE;

endmodule

`default_nettype wire

//--- verilog/connect_four_top.sv
`timescale 1ns/1ps
`default_nettype none

module connect_four_top import c4_pkg::*; (
	input  logic    clk,
	input  logic    reset_n,
	input  scan_t   scan,
	output logic    plot,
	output pixel_t  pixel,
	output player_t turn,
	output player_t winner,
	output logic    game_over
);

	col_t    column;
	logic    drop_req;
	logic    col_full;
	row_t    land_row;
	board_t  board;
	player_t found_winner;
	logic    drop_en;
	player_t drop_player;
	move_t   move;
	logic    plot_start;
	logic    plot_done;

	//////////////////////////////////////////////////////////////////////
	// Keyboard side
	//////////////////////////////////////////////////////////////////////

	key_decoder key_decoder_i (
		.clk      (clk),
		.reset_n  (reset_n),
		.scan     (scan),
		.column   (column),
		.drop_req (drop_req)
	);

	game_control game_control_i (
		.clk          (clk),
		.reset_n      (reset_n),
		.drop_req     (drop_req),
		.column       (column),
		.col_full     (col_full),
		.land_row     (land_row),
		.found_winner (found_winner),
		.plot_done    (plot_done),
		.drop_en      (drop_en),
		.drop_player  (drop_player),
		.move         (move),
		.plot_start   (plot_start),
		.turn         (turn),
		.winner       (winner),
		.game_over    (game_over)
	);

	//////////////////////////////////////////////////////////////////////
	// Board and display side
	//////////////////////////////////////////////////////////////////////

	board_memory board_memory_i (
		.clk         (clk),
		.reset_n     (reset_n),
		.column      (column),
		.drop_en     (drop_en),
		.drop_player (drop_player),
		.col_full    (col_full),
		.land_row    (land_row),
		.board       (board)
	);

	win_checker win_checker_i (
		.board        (board),
		.found_winner (found_winner)
	);

	cell_plotter cell_plotter_i (
		.clk        (clk),
		.reset_n    (reset_n),
		.plot_start (plot_start),
		.move       (move),
		.plot       (plot),
		.pixel      (pixel),
		.plot_done  (plot_done)
	);

endmodule

`default_nettype wire

//--- verilog/game_control.sv
`timescale 1ns/1ps
`default_nettype none

module game_control import c4_pkg::*; (
	input  logic    clk,
	input  logic    reset_n,
	input  logic    drop_req,
	input  col_t    column,
	input  logic    col_full,
	input  row_t    land_row,
	input  player_t found_winner,
	input  logic    plot_done,
	output logic    drop_en,
	output player_t drop_player,
	output move_t   move,
	output logic    plot_start,
	output player_t turn,
	output player_t winner,
	output logic    game_over
);

	typedef enum logic [2:0] {
		PLAY,
		WRITE,
		CHECK,
		DRAW,
		OVER
	} state_t;

	state_t state;

	//////////////////////////////////////////////////////////////////////
	// Sequencing of one drop
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state      <= PLAY;
			turn       <= PLAYER_RED;
			winner     <= PLAYER_NONE;
			plot_start <= 1'b0;
		end else begin
			plot_start <= 1'b0;
			case (state)
				PLAY: begin
					if (drop_req && !col_full)
						state <= WRITE;
				end
				WRITE: state <= CHECK; // Board cell written on this edge
				CHECK: begin
					winner     <= found_winner; // Sees the updated board
					plot_start <= 1'b1;
					state      <= DRAW;
				end
				DRAW: begin
					if (plot_done) begin
						if (winner != PLAYER_NONE) begin
							state <= OVER;
						end else begin
							turn  <= (turn == PLAYER_RED) ? PLAYER_BLUE : PLAYER_RED;
							state <= PLAY;
						end
					end
				end
				OVER: begin
					// Held until reset
				end
				default: state <= PLAY;
			endcase
		end
	end

	// Move for the plotter, taken before the height moves on
	always_ff @(posedge clk) begin
		if (state == WRITE) begin
			move.column <= column;
			move.row    <= land_row;
			move.player <= turn;
		end
	end

	assign drop_en     = (state == WRITE);
	assign drop_player = turn;
	assign game_over   = (state == OVER);

endmodule

`default_nettype wire

//--- verilog/key_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module key_decoder import c4_pkg::*; (
	input  logic  clk,
	input  logic  reset_n,
	input  scan_t scan,
	output col_t  column,
	output logic  drop_req
);

	logic key_press;

	assign key_press = scan.valid && scan.make; // Break codes fall out here

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			column   <= '0;
			drop_req <= 1'b0;
		end else begin
			drop_req <= 1'b0; // One cycle pulse only
			if (key_press) begin
				case (scan.code)
					KEY_Z:     column <= 3'd0;
					KEY_X:     column <= 3'd1;
					KEY_C:     column <= 3'd2;
					KEY_V:     column <= 3'd3;
					KEY_B:     column <= 3'd4;
					KEY_N:     column <= 3'd5;
					KEY_M:     column <= 3'd6;
					KEY_SPACE: drop_req <= 1'b1;
					default: begin
						// Unknown key, selection stays
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/win_checker.sv
`timescale 1ns/1ps
`default_nettype none

module win_checker import c4_pkg::*; (
	input  board_t  board,
	output player_t found_winner
);

	// Owner of the run starting at (r, c) and stepping by (dr, dc)
	function automatic player_t line_owner(
		input board_t b,
		input int     r,
		input int     c,
		input int     dr,
		input int     dc
	);
		player_t first;
		int      er;
		int      ec;
		logic    same;

		er   = r + dr * (WIN_LEN - 1);
		ec   = c + dc * (WIN_LEN - 1);
		same = 1'b0;
		first = PLAYER_NONE;
		if (er >= 0 && er < NUM_ROWS && ec >= 0 && ec < NUM_COLS) begin
			first = b[3'(r)][3'(c)];
			same  = (first != PLAYER_NONE);
			for (int k = 1; k < WIN_LEN; k++) begin
				if (b[3'(r + k * dr)][3'(c + k * dc)] != first)
					same = 1'b0;
			end
		end
		return same ? first : PLAYER_NONE;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Scan of every window
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		player_t owner;
		int      dr;
		int      dc;

		found_winner = PLAYER_NONE;
		for (int r = 0; r < NUM_ROWS; r++) begin
			for (int c = 0; c < NUM_COLS; c++) begin
				// Horizontal, then down-left, down, down-right
				for (int d = 0; d < 4; d++) begin
					dr    = (d == 0) ? 0 : 1;
					dc    = (d == 0) ? 1 : d - 2;
					owner = line_owner(board, r, c, dr, dc);
					if (owner != PLAYER_NONE)
						found_winner = owner;
				end
			end
		end
	end

endmodule

`default_nettype wire
